/* verilog/mister_frame_pkg.sv */
// --------------------------------------------------
// Frame configuration package
// Status word field positions and the DDR port
// widths shared by the frame glue logic
// --------------------------------------------------

package mister_frame_pkg;

    // OSD status word
    localparam int STATUS_W        = 64;

    // CRT horizontal position
    localparam int HOFFSET_LSB     = 24;   // 4-bit field

    // Horizontal scaling for CRT
    localparam int HSIZE_EN_BIT    = 19;
    localparam int HSIZE_SCALE_LSB = 20;   // 4-bit field

    // HDMI shadow-mask overlay
    localparam int SHADOW_LSB      = 32;   // 3-bit field
    localparam int SHADOW_2X_BIT   = 35;
    localparam int SHADOW_ROT_BIT  = 36;

    // Joystick port on the user connector
    localparam int DB15_BIT        = 37;

    // Rotate and flip options
    localparam int ROT_MODE_LSB    = 38;   // 2-bit field

    // A high bit hides the matching menu item
    localparam int MENUMASK_W      = 16;

    // DDR port
    localparam int DDR_ADDR_W      = 29;
    localparam int DDR_BURST_W     = 8;
    localparam int DDR_BE_W        = 8;    // One enable per byte of a 64-bit word

endpackage

/* verilog/ddr_client_if.sv */
// --------------------------------------------------
// DDR client bus
// Request signals of one DDR master and the busy
// level returned to it by the arbiter
// --------------------------------------------------

`timescale 1ns/1ps

interface ddr_client_if;

    logic [mister_frame_pkg::DDR_BURST_W-1:0] burstcnt;
    logic [mister_frame_pkg::DDR_ADDR_W-1:0]  addr;
    logic                                     rd;      // Only while busy is low
    logic                                     we;
    logic [mister_frame_pkg::DDR_BE_W-1:0]    be;
    logic                                     busy;    // Back-pressure from the port

    // Request side
    modport client (
        output burstcnt, addr, rd, we, be,
        input  busy
    );

    // Arbiter side
    modport mux (
        input  burstcnt, addr, rd, we, be,
        output busy
    );

endinterface

/* verilog/status_decode.sv */
// --------------------------------------------------
// Status word decoder
// Registers the OSD settings taken from the status
// word and builds the mask of hidden menu items
// --------------------------------------------------

`timescale 1ns/1ps

module status_decode #(
    parameter bit ROTATE_MENU = 1'b1  // Rotate options live in the extra menu item
)(
    input  logic                                    clk_sys,
    input  logic                                    arst_n,
    input  logic [mister_frame_pkg::STATUS_W-1:0]   status,
    input  logic                                    core_mod,      // Vertical game
    input  logic                                    rotate,
    input  logic                                    direct_video,
    output logic [3:0]                              hoffset,
    output logic                                    hsize_enable,
    output logic [3:0]                              hsize_scale,
    output logic [2:0]                              shadowmask,
    output logic                                    shadowmask_2x,
    output logic                                    shadowmask_rot,
    output logic                                    db15_en,
    output logic [1:0]                              rotate_osd,    // bit 0 rotate, bit 1 flip
    output logic [mister_frame_pkg::MENUMASK_W-1:0] status_menumask
);

    logic [2:0] shadow_field;
    logic       hsize_field;
    logic [1:0] rot_mode;
    logic [1:0] rot_next;
    logic [mister_frame_pkg::MENUMASK_W-1:0] mask_next;

    assign shadow_field = status[mister_frame_pkg::SHADOW_LSB +: 3];
    assign hsize_field  = status[mister_frame_pkg::HSIZE_EN_BIT];
    assign rot_mode     = status[mister_frame_pkg::ROT_MODE_LSB +: 2];

    always_comb begin
        case (rot_mode)
            2'd1:    rot_next = 2'd0;   // No rotation
            2'd2:    rot_next = 2'd2;   // Flip only
            default: rot_next = 2'd1;
        endcase
    end

    always_comb begin
        mask_next    = '0;
        mask_next[4] = ROTATE_MENU ? ~core_mod : 1'b1;
        mask_next[3] = shadow_field == 3'd0;   // Shadow-mask filter off
        mask_next[2] = ~hsize_field;           // Horizontal scaling
        mask_next[1] = ROTATE_MENU ? 1'b1 : ~core_mod;
        mask_next[0] = direct_video;
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hoffset         <= '0;
            hsize_enable    <= 1'b0;
            hsize_scale     <= '0;
            shadowmask      <= '0;
            shadowmask_2x   <= 1'b0;
            shadowmask_rot  <= 1'b0;
            db15_en         <= 1'b0;
            rotate_osd      <= '0;
            status_menumask <= '0;
        end else begin
            hoffset         <= status[mister_frame_pkg::HOFFSET_LSB +: 4];
            hsize_enable    <= hsize_field;
            hsize_scale     <= status[mister_frame_pkg::HSIZE_SCALE_LSB +: 4];
            shadowmask      <= shadow_field;
            shadowmask_2x   <= status[mister_frame_pkg::SHADOW_2X_BIT];
            // Vertical games on a rotated screen flip the mask orientation
            shadowmask_rot  <= (core_mod & rotate) ^ status[mister_frame_pkg::SHADOW_ROT_BIT];
            db15_en         <= status[mister_frame_pkg::DB15_BIT];
            rotate_osd      <= rot_next;
            status_menumask <= mask_next;
        end
    end

endmodule

/* verilog/sync_shift.sv */
// --------------------------------------------------
// Horizontal sync shifter
// Delays hs and vs by a programmable number of
// pixel enables to move the picture on a CRT
// --------------------------------------------------

`timescale 1ns/1ps

module sync_shift #(
    parameter int OFFSET_W = 4
)(
    input  logic                clk_sys,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic                hs,
    input  logic                vs,
    input  logic [OFFSET_W-1:0] hoffset,   // Pixels to move right
    output logic                hs_out,
    output logic                vs_out
);

    localparam int DEPTH = 2 ** OFFSET_W;

    // Pairs seen on earlier enables, entry 0 is the most recent
    logic [DEPTH-2:0][1:0] hist;

    // Tap k holds the pair sampled k enables ago, tap 0 is the live input
    logic [DEPTH-1:0][1:0] taps;

    assign taps = {hist, hs, vs};

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hist   <= '0;
            hs_out <= 1'b0;
            vs_out <= 1'b0;
        end else if (pxl_cen) begin
            hist             <= taps[DEPTH-2:0];   // Oldest pair drops out
            {hs_out, vs_out} <= taps[hoffset];
        end
    end

endmodule

/* verilog/ddr_mux.sv */
// --------------------------------------------------
// DDR port arbiter
// Gives the port to the fast loader while a download
// runs and to the screen rotation otherwise
// --------------------------------------------------

`timescale 1ns/1ps

module ddr_mux (
    input  logic                                     clk_sys,
    input  logic                                     arst_n,
    input  logic                                     downloading,
    ddr_client_if.mux                                ld,    // Fast load
    ddr_client_if.mux                                rot,   // Screen rotation
    input  logic                                     ddr_busy,
    output logic [mister_frame_pkg::DDR_BURST_W-1:0] ddr_burstcnt,
    output logic [mister_frame_pkg::DDR_ADDR_W-1:0]  ddr_addr,
    output logic                                     ddr_rd,
    output logic                                     ddr_we,
    output logic [mister_frame_pkg::DDR_BE_W-1:0]    ddr_be
);

    logic sel;   // High selects the loader

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            sel <= 1'b0;
        end else begin
            sel <= downloading;
        end
    end

    // Requests pass straight through from the owner
    assign ddr_burstcnt = sel ? ld.burstcnt : rot.burstcnt;
    assign ddr_addr     = sel ? ld.addr     : rot.addr;
    assign ddr_rd       = sel ? ld.rd       : rot.rd;
    assign ddr_we       = sel ? ld.we       : rot.we;
    assign ddr_be       = sel ? ld.be       : rot.be;

    // The client without the port sees a permanent busy and stalls
    assign ld.busy  = sel ? ddr_busy : 1'b1;
    assign rot.busy = sel ? 1'b1     : ddr_busy;

endmodule

/* verilog/mister_frame.sv */
// --------------------------------------------------
// Frame glue top level
// OSD settings decoding, CRT sync shifting and DDR
// sharing between fast load and screen rotation
// --------------------------------------------------

`timescale 1ns/1ps

module mister_frame #(
    parameter bit ROTATE_MENU = 1'b1,
    parameter int OFFSET_W    = 4
)(
    input  logic                                     clk_sys,
    input  logic                                     arst_n,
    // OSD
    input  logic [mister_frame_pkg::STATUS_W-1:0]    status,
    input  logic                                     core_mod,
    input  logic                                     rotate,
    input  logic                                     direct_video,
    // Base video sync
    input  logic                                     pxl_cen,
    input  logic                                     hs,
    input  logic                                     vs,
    output logic                                     hs_out,
    output logic                                     vs_out,
    // Settings
    output logic                                     hsize_enable,
    output logic [3:0]                               hsize_scale,
    output logic [2:0]                               shadowmask,
    output logic                                     shadowmask_2x,
    output logic                                     shadowmask_rot,
    output logic                                     db15_en,
    output logic [1:0]                               rotate_osd,
    output logic [mister_frame_pkg::MENUMASK_W-1:0]  status_menumask,
    input  logic                                     downloading,
    // Fast DDR load, read only
    input  logic [mister_frame_pkg::DDR_BURST_W-1:0] ld_burstcnt,
    input  logic [mister_frame_pkg::DDR_ADDR_W-1:0]  ld_addr,
    input  logic                                     ld_rd,
    output logic                                     ld_busy,
    // Screen rotation
    input  logic [mister_frame_pkg::DDR_BURST_W-1:0] rot_burstcnt,
    input  logic [mister_frame_pkg::DDR_ADDR_W-1:0]  rot_addr,
    input  logic                                     rot_rd,
    input  logic                                     rot_we,
    input  logic [mister_frame_pkg::DDR_BE_W-1:0]    rot_be,
    output logic                                     rot_busy,
    // DDR port
    input  logic                                     ddr_busy,
    output logic [mister_frame_pkg::DDR_BURST_W-1:0] ddr_burstcnt,
    output logic [mister_frame_pkg::DDR_ADDR_W-1:0]  ddr_addr,
    output logic                                     ddr_rd,
    output logic                                     ddr_we,
    output logic [mister_frame_pkg::DDR_BE_W-1:0]    ddr_be
);

    logic [OFFSET_W-1:0] hoffset;

    ddr_client_if ld_bus ();
    ddr_client_if rot_bus ();

    assign ld_bus.burstcnt  = ld_burstcnt;
    assign ld_bus.addr      = ld_addr;
    assign ld_bus.rd        = ld_rd;
    assign ld_bus.we        = 1'b0;   // Loader never writes
    assign ld_bus.be        = '1;
    assign ld_busy          = ld_bus.busy;

    assign rot_bus.burstcnt = rot_burstcnt;
    assign rot_bus.addr     = rot_addr;
    assign rot_bus.rd       = rot_rd;
    assign rot_bus.we       = rot_we;
    assign rot_bus.be       = rot_be;
    assign rot_busy         = rot_bus.busy;

    status_decode #(
        .ROTATE_MENU     ( ROTATE_MENU     )
    ) u_decode (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .status          ( status          ),
        .core_mod        ( core_mod        ),
        .rotate          ( rotate          ),
        .direct_video    ( direct_video    ),
        .hoffset         ( hoffset         ),
        .hsize_enable    ( hsize_enable    ),
        .hsize_scale     ( hsize_scale     ),
        .shadowmask      ( shadowmask      ),
        .shadowmask_2x   ( shadowmask_2x   ),
        .shadowmask_rot  ( shadowmask_rot  ),
        .db15_en         ( db15_en         ),
        .rotate_osd      ( rotate_osd      ),
        .status_menumask ( status_menumask )
    );

    sync_shift #(
        .OFFSET_W ( OFFSET_W )
    ) u_shift (
        .clk_sys  ( clk_sys  ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .hoffset  ( hoffset  ),
        .hs_out   ( hs_out   ),
        .vs_out   ( vs_out   )
    );

    ddr_mux u_ddrmux (
        .clk_sys      ( clk_sys      ),
        .arst_n       ( arst_n       ),
        .downloading  ( downloading  ),
        .ld           ( ld_bus       ),
        .rot          ( rot_bus      ),
        .ddr_busy     ( ddr_busy     ),
        .ddr_burstcnt ( ddr_burstcnt ),
        .ddr_addr     ( ddr_addr     ),
        .ddr_rd       ( ddr_rd       ),
        .ddr_we       ( ddr_we       ),
        .ddr_be       ( ddr_be       )
    );

endmodule

/* test/tb_mister_frame.sv */
// --------------------------------------------------
// Frame glue testbench
// Random stimulus on the OSD, sync and DDR ports,
// checked every cycle against reference models
// --------------------------------------------------

`timescale 1ns/1ps

module tb_mister_frame;

    localparam int RESET_CYCLES = 3;
    localparam int SWEEP_CYCLES = 256;   // All directed decode combinations
    localparam int RAND_CYCLES  = 600;
    localparam int HOLD_CYCLES  = 200;
    localparam int HOLD_VALUES  = 6;
    localparam int TOTAL_CYCLES = RESET_CYCLES + SWEEP_CYCLES + RAND_CYCLES
                                  + HOLD_CYCLES * HOLD_VALUES;
    localparam int TIMEOUT_NS   = 2 * TOTAL_CYCLES * 8;
    localparam int SYNC_DEPTH   = 16;    // 2 ** OFFSET_W

    logic                                     clk_sys = 1'b0;
    logic                                     arst_n;
    logic [mister_frame_pkg::STATUS_W-1:0]    status;
    logic                                     core_mod, rotate, direct_video;
    logic                                     pxl_cen, hs, vs, hs_out, vs_out;
    logic                                     hsize_enable, shadowmask_2x, shadowmask_rot, db15_en;
    logic [3:0]                               hsize_scale;
    logic [2:0]                               shadowmask;
    logic [1:0]                               rotate_osd;
    logic [mister_frame_pkg::MENUMASK_W-1:0]  status_menumask;
    logic                                     downloading;
    logic [mister_frame_pkg::DDR_BURST_W-1:0] ld_burstcnt, rot_burstcnt, ddr_burstcnt;
    logic [mister_frame_pkg::DDR_ADDR_W-1:0]  ld_addr, rot_addr, ddr_addr;
    logic                                     ld_rd, ld_busy, rot_rd, rot_we, rot_busy;
    logic [mister_frame_pkg::DDR_BE_W-1:0]    rot_be, ddr_be;
    logic                                     ddr_busy, ddr_rd, ddr_we;

    // Model state
    logic [31:0] rng_state;
    logic [1:0]  sync_hist [SYNC_DEPTH];   // Entry 0 is the newest pair
    logic [1:0]  exp_sync;
    logic [3:0]  hoff_q;                   // Decoded offset seen by the shifter
    logic        sel_m;
    int          switch_count;

    mister_frame #(
        .ROTATE_MENU ( 1'b1 ),
        .OFFSET_W    ( 4    )
    ) i_dut (.*);

    always #4 clk_sys = ~clk_sys;

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_settings(input logic exp_en, input logic [3:0] exp_scale,
                                  input logic [2:0] exp_shadow, input logic exp_2x,
                                  input logic exp_rot, input logic exp_db15,
                                  input logic [1:0] exp_osd);
        logic [12:0] act;
        logic [12:0] exp;
        act = {hsize_enable, hsize_scale, shadowmask, shadowmask_2x, shadowmask_rot,
               db15_en, rotate_osd};
        exp = {exp_en, exp_scale, exp_shadow, exp_2x, exp_rot, exp_db15, exp_osd};
        if (act !== exp)
            report_mismatch($sformatf("settings %b, expected %b", act, exp));
    endtask

    task automatic check_menumask(input logic [mister_frame_pkg::MENUMASK_W-1:0] exp);
        if (status_menumask !== exp)
            report_mismatch($sformatf("menu mask %h, expected %h", status_menumask, exp));
    endtask

    task automatic check_sync(input logic exp_hs, input logic exp_vs);
        if ({hs_out, vs_out} !== {exp_hs, exp_vs})
            report_mismatch($sformatf("hs/vs %b%b, expected %b%b, offset %0d",
                                      hs_out, vs_out, exp_hs, exp_vs, hoff_q));
    endtask

    task automatic check_ddr(input logic [mister_frame_pkg::DDR_BURST_W-1:0] exp_burst,
                             input logic [mister_frame_pkg::DDR_ADDR_W-1:0] exp_addr,
                             input logic exp_rd, input logic exp_we,
                             input logic [mister_frame_pkg::DDR_BE_W-1:0] exp_be,
                             input logic exp_ld_busy, input logic exp_rot_busy);
        if ({ddr_burstcnt, ddr_addr, ddr_rd, ddr_we, ddr_be, ld_busy, rot_busy} !==
            {exp_burst, exp_addr, exp_rd, exp_we, exp_be, exp_ld_busy, exp_rot_busy})
            report_mismatch($sformatf("ddr %h/%h rd%b we%b be%h busy %b%b, sel %b",
                                      ddr_burstcnt, ddr_addr, ddr_rd, ddr_we, ddr_be,
                                      ld_busy, rot_busy, sel_m));
    endtask

    // Waits one edge, advances the models with the sampled inputs and compares
    task automatic step_and_check();
        logic [1:0]  mode;
        logic [1:0]  exp_osd;
        logic [mister_frame_pkg::MENUMASK_W-1:0] exp_mask;
        int          i;
        @(posedge clk_sys);
        #1;
        mode     = status[mister_frame_pkg::ROT_MODE_LSB +: 2];
        exp_osd  = (mode == 2'd1) ? 2'd0 : (mode == 2'd2) ? 2'd2 : 2'd1;
        exp_mask = '0;
        exp_mask[4] = ~core_mod;
        exp_mask[3] = status[mister_frame_pkg::SHADOW_LSB +: 3] == 3'd0;
        exp_mask[2] = ~status[mister_frame_pkg::HSIZE_EN_BIT];
        exp_mask[1] = 1'b1;
        exp_mask[0] = direct_video;
        check_settings(status[mister_frame_pkg::HSIZE_EN_BIT],
                       status[mister_frame_pkg::HSIZE_SCALE_LSB +: 4],
                       status[mister_frame_pkg::SHADOW_LSB +: 3],
                       status[mister_frame_pkg::SHADOW_2X_BIT],
                       (core_mod & rotate) ^ status[mister_frame_pkg::SHADOW_ROT_BIT],
                       status[mister_frame_pkg::DB15_BIT], exp_osd);
        check_menumask(exp_mask);
        if (pxl_cen) begin
            for (i = SYNC_DEPTH - 1; i > 0; i--)
                sync_hist[i] = sync_hist[i-1];
            sync_hist[0] = {hs, vs};
            exp_sync     = sync_hist[hoff_q];   // Offset from the previous cycle
        end
        check_sync(exp_sync[1], exp_sync[0]);
        hoff_q = status[mister_frame_pkg::HOFFSET_LSB +: 4];
        sel_m = downloading;
        if (sel_m)
            check_ddr(ld_burstcnt, ld_addr, ld_rd, 1'b0, '1, ddr_busy, 1'b1);
        else
            check_ddr(rot_burstcnt, rot_addr, rot_rd, rot_we, rot_be, 1'b1, ddr_busy);
    endtask

    task automatic drive_random(input logic hold_offset, input logic [3:0] offset);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        status = {next_random(), next_random()};
        if (hold_offset)
            status[mister_frame_pkg::HOFFSET_LSB +: 4] = offset;
        r = next_random();
        a = next_random();
        b = next_random();
        core_mod     = r[0];
        rotate       = r[1];
        direct_video = r[2];
        pxl_cen      = r[3];
        hs           = r[4];
        vs           = r[5];
        ddr_busy     = r[6];
        if (r[10:8] == 3'd0) begin   // Switch roughly every 8 cycles
            downloading  = ~downloading;
            switch_count = switch_count + 1;
        end
        ld_burstcnt  = r[23:16];
        rot_burstcnt = r[31:24];
        ld_addr      = a[mister_frame_pkg::DDR_ADDR_W-1:0];
        rot_addr     = b[mister_frame_pkg::DDR_ADDR_W-1:0];
        rot_be       = a[31:24] ^ b[7:0];
        // Requests only where the client sees busy low
        ld_rd  = r[11] & sel_m & ~ddr_busy;
        rot_rd = r[12] & ~sel_m & ~ddr_busy;
        rot_we = r[13] & ~r[12] & ~sel_m & ~ddr_busy;
    endtask

    task automatic drive_sweep(input logic [7:0] combo);
        drive_random(1'b0, 4'd0);
        core_mod     = combo[0];
        direct_video = combo[1];
        status[mister_frame_pkg::SHADOW_LSB +: 3] = combo[2] ? 3'd0 :
            {status[mister_frame_pkg::SHADOW_LSB+1 +: 2], 1'b1};
        status[mister_frame_pkg::HSIZE_EN_BIT]     = combo[3];
        status[mister_frame_pkg::ROT_MODE_LSB +: 2] = combo[5:4];
        rotate                                     = combo[6];
        status[mister_frame_pkg::SHADOW_ROT_BIT]   = combo[7];
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  offset;
        rng_state    = 32'd22;
        arst_n       = 1'b1;
        status       = '0;
        {core_mod, rotate, direct_video, pxl_cen, hs, vs} = '0;
        downloading  = 1'b0;
        {ld_burstcnt, ld_addr, ld_rd} = '0;
        {rot_burstcnt, rot_addr, rot_rd, rot_we, rot_be} = '0;
        ddr_busy     = 1'b0;
        for (int i = 0; i < SYNC_DEPTH; i++)
            sync_hist[i] = 2'b00;
        exp_sync     = 2'b00;
        hoff_q       = 4'd0;
        sel_m        = 1'b0;
        switch_count = 0;
        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #1;
        check_settings(1'b0, 4'd0, 3'd0, 1'b0, 1'b0, 1'b0, 2'd0);
        check_menumask('0);
        check_sync(1'b0, 1'b0);
        check_ddr(rot_burstcnt, rot_addr, rot_rd, rot_we, rot_be, 1'b1, ddr_busy);
        arst_n = 1'b1;
        for (int c = 0; c < SWEEP_CYCLES; c++) begin
            drive_sweep(c[7:0]);
            step_and_check();
        end
        repeat (RAND_CYCLES) begin
            drive_random(1'b0, 4'd0);
            step_and_check();
        end
        for (int v = 0; v < HOLD_VALUES; v++) begin
            r      = next_random();
            offset = (v == 0) ? 4'd0 : (v == 1) ? 4'd15 : r[3:0];   // Both ends first
            repeat (HOLD_CYCLES) begin
                drive_random(1'b1, offset);
                step_and_check();
            end
        end
        if (switch_count < 4) begin
            $display("Error: downloading switched only %0d times", switch_count);
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* mister_frame.f */
verilog/mister_frame_pkg.sv
verilog/ddr_client_if.sv
verilog/status_decode.sv
verilog/sync_shift.sv
verilog/ddr_mux.sv
verilog/mister_frame.sv
test/tb_mister_frame.sv

/* Bender.yml */
package:
  name: mister_frame

sources:
  - verilog/mister_frame_pkg.sv
  - verilog/ddr_client_if.sv
  - verilog/status_decode.sv
  - verilog/sync_shift.sv
  - verilog/ddr_mux.sv
  - verilog/mister_frame.sv
  - target: test
    files:
      - test/tb_mister_frame.sv
